/* eeprom_defines.svh */
`ifndef EEPROM_DEFINES_SVH
`define EEPROM_DEFINES_SVH

// byte address into the 2048 byte array
`define EE_ADDR_W 11

// fixed upper nibble of the control byte
`define EE_DEV_CODE 4'b1010

// one SCL period is four of these
`define EE_QTR_CLKS 4

`endif

/* eeprom_pkg.sv */
`include "eeprom_defines.svh"

package eeprom_pkg;

    typedef struct packed {
        logic                  write;
        logic [`EE_ADDR_W-1:0] addr;
        logic [7:0]            wdata;
    } ee_req_t;

    typedef struct packed {
        logic       err;   // device did not acknowledge
        logic [7:0] rdata;
    } ee_rsp_t;

    // a write step with mack set carries no byte, only the stop condition
    typedef struct packed {
        logic       start; // start, or repeated start when the bus is held
        logic       read;
        logic       mack;  // 1 = master NACK after a read byte
        logic       stop;
        logic [7:0] data;
    } ee_byte_cmd_t;

    typedef struct packed {
        logic       nack;
        logic [7:0] data;
    } ee_byte_rsp_t;

endpackage

/* ee_wb_front.sv */
`include "eeprom_defines.svh"

module ee_wb_front (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`EE_ADDR_W-1:0] wb_adr,
    input  logic [7:0]            wb_dat_w,
    output logic [7:0]            wb_dat_r,
    output logic                  wb_ack,
    output logic                  wb_err,
    output eeprom_pkg::ee_req_t   req,
    output logic                  req_valid,
    input  logic                  req_ready,
    input  eeprom_pkg::ee_rsp_t   rsp,
    input  logic                  rsp_valid
);

    logic busy;  // a bus cycle is being served
    logic start;

    // ack/err still high means the host has not yet dropped stb
    assign start = wb_cyc && wb_stb && !busy && !wb_ack && !wb_err;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy      <= 1'b0;
            req_valid <= 1'b0;
            wb_ack    <= 1'b0;
            wb_err    <= 1'b0;
        end
        else
        begin
            wb_ack <= rsp_valid && !rsp.err;
            wb_err <= rsp_valid && rsp.err;
            if (start)
            begin
                busy      <= 1'b1;
                req_valid <= 1'b1;
            end
            else if (req_valid && req_ready)
                req_valid <= 1'b0;
            if (rsp_valid)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (start)
        begin
            req.write <= wb_we;
            req.addr  <= wb_adr;
            req.wdata <= wb_dat_w;
        end
        if (rsp_valid)
            wb_dat_r <= rsp.rdata;
    end

    // ack or err lasts a single cycle
    a_term_one_cycle: assert property (@(posedge CLK) disable iff (RESET)
        (wb_ack || wb_err) |=> !(wb_ack || wb_err));
    a_term_in_cycle: assert property (@(posedge CLK) disable iff (RESET)
        (wb_ack || wb_err) |-> (wb_cyc && wb_stb));

endmodule

/* ee_txn_seq.sv */
`include "eeprom_defines.svh"

module ee_txn_seq (
    input  logic                     CLK,
    input  logic                     RESET,
    input  eeprom_pkg::ee_req_t      req,
    input  logic                     req_valid,
    output logic                     req_ready,
    output eeprom_pkg::ee_rsp_t      rsp,
    output logic                     rsp_valid,
    output eeprom_pkg::ee_byte_cmd_t cmd,
    output logic                     cmd_valid,
    input  logic                     cmd_ready,
    input  eeprom_pkg::ee_byte_rsp_t byte_rsp,
    input  logic                     byte_done
);
    import eeprom_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE, S_CTRL, S_ADDR, S_DATA, S_RS_CTRL, S_RD_DATA, S_STOP
    } state_t;

    state_t  state;
    ee_req_t req_q;

    assign req_ready = (state == S_IDLE);

    always_comb
    begin
        cmd = '0;
        case (state)
            S_CTRL:
            begin
                cmd.start = 1'b1;
                cmd.data  = {`EE_DEV_CODE, req_q.addr[`EE_ADDR_W-1:8], 1'b0};
            end
            S_ADDR:    cmd.data = req_q.addr[7:0];
            S_DATA:
            begin
                cmd.stop = 1'b1;
                cmd.data = req_q.wdata;
            end
            S_RS_CTRL:
            begin
                cmd.start = 1'b1;
                cmd.data  = {`EE_DEV_CODE, req_q.addr[`EE_ADDR_W-1:8], 1'b1};
            end
            S_RD_DATA:
            begin
                cmd.read = 1'b1;
                cmd.mack = 1'b1;  // single byte read ends with NACK
                cmd.stop = 1'b1;
                cmd.data = 8'hff;
            end
            S_STOP:
            begin
                cmd.mack = 1'b1;  // stop only
                cmd.stop = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            cmd_valid <= 1'b0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= 1'b0;
            if (cmd_valid && cmd_ready)
                cmd_valid <= 1'b0;
            if (state == S_IDLE)
            begin
                if (req_valid)
                begin
                    state     <= S_CTRL;
                    cmd_valid <= 1'b1;
                end
            end
            else if (byte_done)
            begin
                case (state)
                    S_CTRL:    state <= byte_rsp.nack ? S_STOP : S_ADDR;
                    S_ADDR:    state <= byte_rsp.nack ? S_STOP :
                                        req_q.write ? S_DATA : S_RS_CTRL;
                    S_RS_CTRL: state <= byte_rsp.nack ? S_STOP : S_RD_DATA;
                    default:   state <= S_IDLE;  // last byte, stop already on the bus
                endcase
                if (state == S_DATA || state == S_RD_DATA || state == S_STOP)
                    rsp_valid <= 1'b1;
                else
                    cmd_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (req_valid && req_ready)
            req_q <= req;
        if (byte_done)
        begin
            rsp.err   <= byte_rsp.nack || (state == S_STOP);
            rsp.rdata <= byte_rsp.data;
        end
    end

    // one byte in flight between sequencer and bit engine
    a_one_in_flight: assert property (@(posedge CLK) disable iff (RESET)
        (cmd_valid && cmd_ready) |=> (!cmd_valid until_with byte_done));

endmodule

/* ee_bit_engine.sv */
`include "eeprom_defines.svh"

module ee_bit_engine (
    input  logic                     CLK,
    input  logic                     RESET,
    input  eeprom_pkg::ee_byte_cmd_t cmd,
    input  logic                     cmd_valid,
    output logic                     cmd_ready,
    output eeprom_pkg::ee_byte_rsp_t byte_rsp,
    output logic                     byte_done,
    output logic                     scl,
    output logic                     sda_drive_low,
    input  logic                     sda_in
);
    import eeprom_pkg::*;

    localparam int QCW = $clog2(`EE_QTR_CLKS);

    typedef enum logic [2:0] {PH_IDLE, PH_START, PH_BITS, PH_WAIT, PH_STOP} phase_t;

    phase_t         phase;
    ee_byte_cmd_t   cmd_q;
    logic [QCW-1:0] qcnt;
    logic [1:0]     q;       // quarter of the SCL period, high in 2 and 3
    logic [3:0]     bitcnt;  // 8 is the ack bit
    logic [7:0]     sh;      // shifts out on writes, in on reads
    logic           qtick;
    logic           running;
    logic           accept;
    logic           stop_only;
    logic           sda_low_next;

    assign cmd_ready = (phase == PH_IDLE) || (phase == PH_WAIT);
    assign accept    = cmd_valid && cmd_ready;
    assign running   = (phase == PH_START) || (phase == PH_BITS) || (phase == PH_STOP);
    assign qtick     = running && (qcnt == QCW'(`EE_QTR_CLKS - 1));
    assign stop_only = !cmd_q.read && cmd_q.mack;

    // SDA level for the second quarter, SCL is low then
    always_comb
    begin
        case (phase)
            PH_START: sda_low_next = 1'b0;
            PH_STOP:  sda_low_next = 1'b1;
            default:
            begin
                if (bitcnt[3])
                    sda_low_next = cmd_q.read && !cmd_q.mack;  // master ack
                else
                    sda_low_next = !cmd_q.read && !sh[7];
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase         <= PH_IDLE;
            qcnt          <= '0;
            q             <= '0;
            bitcnt        <= '0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
            byte_done     <= 1'b0;
        end
        else
        begin
            byte_done <= 1'b0;
            if (accept)
            begin
                qcnt   <= '0;
                q      <= '0;
                bitcnt <= '0;
                scl    <= 1'b0;
                if (!cmd.read && cmd.mack)
                    phase <= PH_STOP;
                else if (cmd.start)
                    phase <= PH_START;
                else
                    phase <= PH_BITS;
            end
            else if (running)
            begin
                qcnt <= qtick ? '0 : qcnt + 1'b1;
                if (qtick)
                begin
                    q   <= q + 2'd1;
                    scl <= (q == 2'd1) || (q == 2'd2);
                    case (q)
                        2'd0: sda_drive_low <= sda_low_next;
                        2'd2:
                        begin
                            if (phase == PH_START)
                                sda_drive_low <= 1'b1;  // start, SDA falls with SCL high
                            else if (phase == PH_STOP)
                                sda_drive_low <= 1'b0;  // stop, SDA rises with SCL high
                        end
                        2'd3:
                        begin
                            if (phase == PH_START)
                                phase <= PH_BITS;
                            else if (phase == PH_BITS)
                            begin
                                if (bitcnt == 4'd8)
                                begin
                                    byte_done <= 1'b1;
                                    phase     <= cmd_q.stop ? PH_STOP : PH_WAIT;
                                end
                                else
                                    bitcnt <= bitcnt + 4'd1;
                            end
                            else
                            begin
                                phase     <= PH_IDLE;
                                scl       <= 1'b1;
                                byte_done <= stop_only;
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    // sample at the middle of SCL high
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            cmd_q         <= cmd;
            sh            <= cmd.data;
            byte_rsp.nack <= 1'b0;
        end
        else if (qtick && q == 2'd2 && phase == PH_BITS)
        begin
            if (bitcnt[3])
            begin
                byte_rsp.nack <= !cmd_q.read && sda_in;
                byte_rsp.data <= sh;
            end
            else
                sh <= {sh[6:0], sda_in};
        end
    end

    a_sda_scl_low: assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_drive_low) |-> (!scl || phase inside {PH_START, PH_STOP}));

endmodule

/* ee_ctrl_top.sv */
`include "eeprom_defines.svh"

module ee_ctrl_top (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`EE_ADDR_W-1:0] wb_adr,
    input  logic [7:0]            wb_dat_w,
    output logic [7:0]            wb_dat_r,
    output logic                  wb_ack,
    output logic                  wb_err,
    output logic                  scl,
    inout  wire                   sda
);
    import eeprom_pkg::*;

    ee_req_t      req;
    logic         req_valid;
    logic         req_ready;
    ee_rsp_t      rsp;
    logic         rsp_valid;
    ee_byte_cmd_t cmd;
    logic         cmd_valid;
    logic         cmd_ready;
    ee_byte_rsp_t byte_rsp;
    logic         byte_done;
    logic         sda_drive_low;
    logic         sda_in;

    // open drain, the pull-up supplies the high level
    assign sda    = sda_drive_low ? 1'b0 : 1'bz;
    assign sda_in = sda;

    ee_wb_front i_ee_wb_front (
        .CLK, .RESET,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack, .wb_err,
        .req, .req_valid, .req_ready, .rsp, .rsp_valid
    );

    ee_txn_seq i_ee_txn_seq (
        .CLK, .RESET,
        .req, .req_valid, .req_ready, .rsp, .rsp_valid,
        .cmd, .cmd_valid, .cmd_ready, .byte_rsp, .byte_done
    );

    ee_bit_engine i_ee_bit_engine (
        .CLK, .RESET,
        .cmd, .cmd_valid, .cmd_ready, .byte_rsp, .byte_done,
        .scl, .sda_drive_low, .sda_in
    );

endmodule

/* tb_eeprom_model.sv */
module tb_eeprom_model (
    input  logic scl,
    inout  wire  sda,
    input  logic nack,        // refuse the control byte
    output int   violations
);

    typedef enum logic [2:0] {M_IDLE, M_CTRL, M_ADDR, M_WDATA, M_RDATA, M_SKIP} mstate_t;

    logic [7:0]  mem [0:2047];
    mstate_t     mstate;
    logic        started;
    logic        drive_low;
    logic        send_next;   // master wants the next read byte
    logic [2:0]  block;
    logic [10:0] addr;
    logic [7:0]  shreg;
    logic [7:0]  outbyte;
    int          bitcnt;      // scl rises in this frame, 9 is the ack bit
    int          idle_clks;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = i[7:0] ^ {i[10:8], 5'b0};
        mstate     = M_IDLE;
        started    = 1'b0;
        drive_low  = 1'b0;
        send_next  = 1'b0;
        addr       = '0;
        block      = '0;
        bitcnt     = 0;
        idle_clks  = 0;
        violations = 0;
    end

    // start or stop, legal only on a frame boundary
    task automatic bus_condition(input logic is_start);
        if (started && bitcnt > 1)
            violations++;
        started   = is_start;
        mstate    = is_start ? M_CTRL : M_IDLE;
        bitcnt    = 0;
        idle_clks = 0;
        drive_low = 1'b0;
    endtask

    // after the eighth data bit, scl just fell
    task automatic take_byte();
        case (mstate)
            M_CTRL:
            begin
                if (shreg[7:4] == 4'b1010 && !nack)
                begin
                    drive_low = 1'b1;
                    block     = shreg[3:1];
                    send_next = 1'b1;
                    mstate    = shreg[0] ? M_RDATA : M_ADDR;
                end
                else
                    mstate = M_SKIP;
            end
            M_ADDR:
            begin
                addr      = {block, shreg};
                drive_low = 1'b1;
                mstate    = M_WDATA;
            end
            M_WDATA:
            begin
                mem[addr] = shreg;
                addr      = addr + 1'b1;
                drive_low = 1'b1;
            end
            M_RDATA:   drive_low = 1'b0;  // master drives the ack
            default: ;
        endcase
    endtask

    task automatic end_ack();
        drive_low = 1'b0;
        bitcnt    = 0;
        if (mstate == M_RDATA)
        begin
            if (send_next)
            begin
                outbyte   = mem[addr];
                addr      = addr + 1'b1;
                drive_low = !outbyte[7];
            end
            else
                mstate = M_SKIP;  // master NACK, wait for stop
        end
    endtask

    always @(negedge sda)
        if (scl === 1'b1)
            bus_condition(1'b1);

    always @(posedge sda)
        if (scl === 1'b1)
            bus_condition(1'b0);

    always @(posedge scl)
    begin
        if (!started)
        begin
            idle_clks++;
            if (idle_clks == 8)
                violations++;  // a whole byte clocked with no start
        end
        else
        begin
            bitcnt++;
            if (bitcnt <= 8)
                shreg = {shreg[6:0], sda !== 1'b0};
            else if (mstate == M_RDATA && !drive_low)
                send_next = (sda === 1'b0);
        end
    end

    always @(negedge scl)
    begin
        if (started)
        begin
            if (bitcnt == 8)
                take_byte();
            else if (bitcnt == 9)
                end_ack();
            else if (mstate == M_RDATA && bitcnt >= 1)
                drive_low = !outbyte[7 - bitcnt];
        end
    end

endmodule

/* tb_ee_ctrl.sv */
`include "eeprom_defines.svh"

module tb_ee_ctrl;

    localparam int RESET_CLKS = 16;
    localparam int TXN_CLKS   = 1500;  // clock budget per transaction

    logic                  CLK = 1'b0;
    logic                  RESET;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [`EE_ADDR_W-1:0] wb_adr;
    logic [7:0]            wb_dat_w;
    logic [7:0]            wb_dat_r;
    logic                  wb_ack;
    logic                  wb_err;
    logic                  scl;
    wire                   sda;
    logic                  model_nack;
    int                    violations;

    logic                  t_write [$];
    logic [`EE_ADDR_W-1:0] t_adr [$];
    logic [7:0]            t_dat [$];
    logic                  t_nack [$];
    logic                  t_ack [$];   // 0 means err expected
    int                    n_txn = 0;
    int                    cur_txn = 0;
    int                    checks = 0;
    int                    errors = 0;

    always #4 CLK = ~CLK;

    pullup (sda);

    ee_ctrl_top i_ee_ctrl_top (
        .CLK, .RESET,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack, .wb_err,
        .scl, .sda
    );

    tb_eeprom_model eeprom_model (.scl, .sda, .nack(model_nack), .violations);

    task automatic end_run();
        $display("checks %0d, errors %0d, protocol violations %0d", checks, errors, violations);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else
        begin
            errors++;
            $display("Error %s: %s expected %0h, actual %0h", name, what, exp, act);
        end
    endtask

    task automatic check_bus_idle(input string name);
        check_value(name, "scl", 1, scl);
        check_value(name, "sda", 1, sda);
    endtask

    task automatic load_tests(output logic ok);
        int                    fd;
        int                    n;
        int                    nk;
        logic [8*96-1:0]       text;
        logic [7:0]            op;
        logic [23:0]           res;
        logic [`EE_ADDR_W-1:0] adr;
        logic [7:0]            dat;
        fd = $fopen("ee_testdata.txt", "r");
        if (fd == 0)
            $display("cannot open ee_testdata.txt");
        else
        begin
            while ($fgets(text, fd) > 0)
            begin
                n = $sscanf(text, "%s %h %h %d %s", op, adr, dat, nk, res);
                if (n == 5)  // comment and blank lines do not parse
                begin
                    t_write.push_back(op == "w");
                    t_adr.push_back(adr);
                    t_dat.push_back(dat);
                    t_nack.push_back(nk != 0);
                    t_ack.push_back(res == "ack");
                end
            end
            $fclose(fd);
        end
        n_txn = t_write.size();
        ok = (n_txn > 0);
    endtask

    // starts and ends on a falling edge
    task automatic run_txn(input int idx);
        string      name;
        logic       got_ack;
        logic       got_err;
        logic [7:0] got_dat;
        logic       bus_scl;
        logic       bus_sda;
        name       = $sformatf("txn %0d (%s %03h)", idx, t_write[idx] ? "w" : "r", t_adr[idx]);
        cur_txn    = idx;
        wb_cyc     = 1'b1;
        wb_stb     = 1'b1;
        wb_we      = t_write[idx];
        wb_adr     = t_adr[idx];
        wb_dat_w   = t_write[idx] ? t_dat[idx] : 8'h00;
        model_nack = t_nack[idx];
        do
            @(negedge CLK);
        while (!(wb_ack || wb_err));
        got_ack = wb_ack;
        got_err = wb_err;
        got_dat = wb_dat_r;
        bus_scl = scl;
        bus_sda = sda;
        @(negedge CLK);  // host sees ack/err on this rising edge
        checks++;
        assert (!wb_ack && !wb_err) else
        begin
            errors++;
            $display("%s: wb_ack or wb_err stayed high for more than one cycle", name);
        end
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        model_nack = 1'b0;
        check_value(name, "wb_ack", t_ack[idx], got_ack);
        check_value(name, "wb_err", !t_ack[idx], got_err);
        if (t_ack[idx] && !t_write[idx])
            check_value(name, "read data", t_dat[idx], got_dat);
        if (got_err)
        begin
            check_value(name, "scl after err", 1, bus_scl);
            check_value(name, "sda after err", 1, bus_sda);
        end
    endtask

    initial
    begin
        int   gap;
        logic ok;
        RESET      = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = 8'h00;
        model_nack = 1'b0;
        void'($urandom(32'hedf2_0e1c));
        load_tests(ok);
        if (!ok)
        begin
            errors++;
            $display("no transactions could be read from ee_testdata.txt");
            end_run();
        end
        else
        begin
            repeat (RESET_CLKS) @(negedge CLK);
            RESET = 1'b0;
            @(negedge CLK);
            check_bus_idle("after reset");
            check_value("after reset", "wb_ack", 0, wb_ack);
            check_value("after reset", "wb_err", 0, wb_err);
            for (int i = 0; i < n_txn; i++)
            begin
                gap = $urandom_range(20, 0);
                repeat (gap) @(negedge CLK);
                run_txn(i);
            end
            repeat (40) @(negedge CLK);  // let the last stop finish
            check_bus_idle("end of run");
            check_value("end of run", "protocol violations", 0, violations);
            end_run();
        end
    end

    initial
    begin
        wait (n_txn > 0);
        repeat (RESET_CLKS + n_txn * TXN_CLKS) @(posedge CLK);
        errors++;
        $display("timeout, transaction %0d of %0d did not finish in time", cur_txn, n_txn);
        end_run();
    end

endmodule

/* filelist.f */
+incdir+.
eeprom_pkg.sv
ee_wb_front.sv
ee_txn_seq.sv
ee_bit_engine.sv
ee_ctrl_top.sv
tb_eeprom_model.sv
tb_ee_ctrl.sv

/* Bender.yml */
package:
  name: ee_ctrl

sources:
  - include_dirs:
      - .
    files:
      - eeprom_pkg.sv
      - ee_wb_front.sv
      - ee_txn_seq.sv
      - ee_bit_engine.sv
      - ee_ctrl_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_eeprom_model.sv
      - tb_ee_ctrl.sv

/* ee_testdata.txt */
# op  address  data  nack  result
# r lines give the expected read byte, nack 1 makes the model refuse the control byte
w 123 a5 0 ack
r 123 a5 0 ack
w 023 5a 0 ack
w 723 3c 0 ack
r 123 a5 0 ack
r 023 5a 0 ack
r 723 3c 0 ack
w 023 ff 1 err
r 023 5a 0 ack
r 723 3c 1 err
w 7ff 81 0 ack
w 000 7e 0 ack
r 000 7e 0 ack
r 7ff 81 0 ack
r 456 d6 0 ack
